/* design/uart_frame_pkg.sv */
`default_nettype none

package uart_frame_pkg;

    // data bits carried in one frame.
    localparam int PAYLOAD_SIZE = 8;

    // start bit, payload and stop bit.
    localparam int FRAME_BITS = PAYLOAD_SIZE + 2;

    // counts every bit of a frame.
    localparam int BIT_CNT_WIDTH = $clog2(FRAME_BITS);

    typedef logic [PAYLOAD_SIZE-1:0] payload_t;

    // start sits in bit 0, so it is the first bit on the line.
    typedef struct packed {
        logic     stop;
        payload_t payload;
        logic     start;
    } frame_fields_t;

    // the same frame word, seen as a shift register or as its fields.
    typedef union packed {
        logic [FRAME_BITS-1:0] bits;
        frame_fields_t         fields;
    } uart_frame_u;

endpackage

`default_nettype wire

/* design/uart_link.sv */
`default_nettype none

module uart_link (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst,
    input  wire logic                     i_tx_start,
    input  wire uart_frame_pkg::payload_t i_tx_data,
    input  wire logic                     i_rx,
    output logic                          o_tx,
    output logic                          o_tx_done,
    output uart_frame_pkg::payload_t      o_rx_data,
    output logic                          o_rx_valid,
    output logic                          o_rx_frame_err
);

    // both serial pins stay outside, so the line can be looped or driven directly.
    uart_tx u_tx (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_tx_start (i_tx_start),
        .i_tx_data  (i_tx_data),
        .o_tx       (o_tx),
        .o_tx_done  (o_tx_done)
    );

    uart_rx u_rx (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rx           (i_rx),
        .o_rx_data      (o_rx_data),
        .o_rx_valid     (o_rx_valid),
        .o_rx_frame_err (o_rx_frame_err)
    );

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

module uart_rx (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    input  wire logic                i_rx,
    output uart_frame_pkg::payload_t o_rx_data,
    output logic                     o_rx_valid,
    output logic                     o_rx_frame_err
);

    import uart_timing_pkg::*;
    import uart_frame_pkg::*;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_prev;
    logic                     start_edge;
    logic [1:0]               state;
    logic [DIV_WIDTH-1:0]     div_cnt;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt;
    logic                     half_done;
    logic                     bit_done;
    logic                     sample;
    uart_frame_u              frame_q;
    uart_frame_u              frame_next;

    // the line idles high, so the flops come out of reset at 1.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev && !rx_sync;
    assign half_done  = (div_cnt == DIV_WIDTH'(HALF_BIT - 1));
    assign bit_done   = (div_cnt == DIV_WIDTH'(CLKS_PER_BIT - 1));

    // the start check takes the first sample, later states one per bit period.
    always_comb begin
        case (state)
            S_START: sample = half_done;
            S_DATA:  sample = bit_done;
            S_STOP:  sample = bit_done;
            default: sample = 1'b0;
        endcase
    end

    // New bits enter at the top, so after ten samples the start bit sits in bit 0.
    always_comb begin
        frame_next.bits = {rx_sync, frame_q.bits[FRAME_BITS-1:1]};
    end

    always_ff @(posedge i_clk) begin
        if (sample) begin
            frame_q <= frame_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state          <= S_IDLE;
            div_cnt        <= '0;
            bit_cnt        <= '0;
            o_rx_valid     <= 1'b0;
            o_rx_data      <= '0;
            o_rx_frame_err <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;
            div_cnt    <= div_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    div_cnt <= '0; // restarts so samples land mid-bit.
                    if (start_edge) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA; // a short glitch is dropped.
                    end
                end
                S_DATA: begin
                    if (bit_done) begin
                        div_cnt <= '0;
                        if (bit_cnt == BIT_CNT_WIDTH'(PAYLOAD_SIZE - 1)) begin
                            state <= S_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_STOP: begin
                    if (bit_done) begin
                        state          <= S_IDLE;
                        o_rx_valid     <= 1'b1;
                        o_rx_data      <= frame_next.fields.payload;
                        o_rx_frame_err <= !frame_next.fields.stop; // stop must read high.
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/uart_timing_pkg.sv */
`default_nettype none

package uart_timing_pkg;

    // system clock in hz.
    localparam int CLK_FREQ = 125_000_000;

    // line rate in bits per second.
    localparam int BAUD_RATE = 7_812_500;

    // one bit period in clock cycles.
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;

    // distance from the start edge to the middle of the start bit.
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    // wide enough to count one full bit period.
    localparam int DIV_WIDTH = $clog2(CLKS_PER_BIT);

endpackage

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none

module uart_tx (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst,
    input  wire logic                     i_tx_start,
    input  wire uart_frame_pkg::payload_t i_tx_data,
    output logic                          o_tx,
    output logic                          o_tx_done
);

    import uart_timing_pkg::*;
    import uart_frame_pkg::*;

    localparam logic S_IDLE = 1'b0;
    localparam logic S_SEND = 1'b1;

    logic                     state;
    logic [DIV_WIDTH-1:0]     div_cnt;
    logic                     tick;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt;
    logic                     last_bit;
    uart_frame_u              frame_q;

    assign tick     = (div_cnt == DIV_WIDTH'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_cnt == BIT_CNT_WIDTH'(FRAME_BITS - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1; // runs whether a frame is pending or not.
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
        end else if (tick) begin
            case (state)
                S_IDLE: begin
                    if (i_tx_start) begin
                        state   <= S_SEND;
                        bit_cnt <= '0;
                    end
                end
                S_SEND: begin
                    if (last_bit) begin
                        state <= S_IDLE; // the stop bit has had its full period.
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Reloaded on every idle tick, so the word is ready when the request is taken.
    always_ff @(posedge i_clk) begin
        if (tick) begin
            if (state == S_IDLE) begin
                frame_q.fields.start   <= 1'b0;
                frame_q.fields.payload <= i_tx_data;
                frame_q.fields.stop    <= 1'b1;
            end else begin
                frame_q.bits <= {1'b1, frame_q.bits[FRAME_BITS-1:1]};
            end
        end
    end

    assign o_tx      = (state == S_SEND) ? frame_q.bits[0] : 1'b1;
    assign o_tx_done = (state == S_IDLE);

endmodule

`default_nettype wire

/* list.f */
design/uart_timing_pkg.sv
design/uart_frame_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_link.sv
tests/tb_clock.sv
tests/uart_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the uart_link testbench with verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module uart_link_tb \
    -o uart_link_sim && ./obj_dir/uart_link_sim | tee sim.log
grep -q "^All tests passed$" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic o_clk,
    output logic o_rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD_NS = 4; // 8 ns period.
    localparam int RESET_CYCLES   = 8;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) o_clk = ~o_clk;
        end
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0; // released on a falling edge like the other inputs.
    end

endmodule

`default_nettype wire

/* tests/uart_link_tb.sv */
`default_nettype none

module uart_link_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import uart_timing_pkg::*;
    import uart_frame_pkg::*;

    localparam logic [31:0] LFSR_SEED      = 32'h7516;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
    localparam int          RANDOM_FRAMES  = 16;
    localparam int          TIMEOUT_CYCLES = 30 * FRAME_BITS * CLKS_PER_BIT * 2;

    logic        clk;
    logic        rst;
    logic        tx_start;
    payload_t    tx_data;
    logic        tb_line;
    logic        line_from_tb;
    logic        rx_line;
    logic        tx_line;
    logic        tx_done;
    payload_t    rx_data;
    logic        rx_valid;
    logic        rx_frame_err;
    logic [31:0] lfsr_state;
    int          cycle_count;

    tb_clock u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    assign rx_line = line_from_tb ? tb_line : tx_line; // loopback unless the tb owns the line.

    uart_link i_dut (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_tx_start     (tx_start),
        .i_tx_data      (tx_data),
        .i_rx           (rx_line),
        .o_tx           (tx_line),
        .o_tx_done      (tx_done),
        .o_rx_data      (rx_data),
        .o_rx_valid     (rx_valid),
        .o_rx_frame_err (rx_frame_err)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input payload_t exp, input payload_t act);
        if (exp !== act) begin
            abort_run($sformatf("error: %s expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("error: %s expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (exp != act) begin
            abort_run($sformatf("error: %s expected %h cycles, got %h", name, exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: the tests did not finish in %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic random_byte(output payload_t b);
        b = '0;
        for (int i = 0; i < PAYLOAD_SIZE; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[PAYLOAD_SIZE-2:0], lfsr_state[0]}; // one step per bit.
        end
    endtask

    task automatic send_frame(input payload_t b);
        @(negedge clk);
        while (!tx_done) @(negedge clk);
        tx_data  = b;
        tx_start = 1'b1;
        while (tx_done) @(negedge clk);
        tx_start = 1'b0;
    endtask

    task automatic wait_for_byte(output payload_t data, output logic err);
        @(negedge clk);
        while (!rx_valid) @(negedge clk);
        data = rx_data;
        err  = rx_frame_err;
    endtask

    task automatic drive_line_frame(input payload_t b, input logic stop_bit);
        logic [FRAME_BITS-1:0] bits;
        bits = {stop_bit, b, 1'b0};
        @(negedge clk);
        tb_line = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk); // idle so the receiver sees a clean edge.
        for (int i = 0; i < FRAME_BITS; i++) begin
            tb_line = bits[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        tb_line = 1'b1;
    endtask

    task automatic verify_reset_values();
        repeat (2 * CLKS_PER_BIT) begin
            @(negedge clk);
            check_bit("o_tx", 1'b1, tx_line);
            check_bit("o_tx_done", 1'b1, tx_done);
            check_bit("o_rx_valid", 1'b0, rx_valid);
        end
        check_byte("o_rx_data", '0, rx_data);
        check_bit("o_rx_frame_err", 1'b0, rx_frame_err);
    endtask

    task automatic trace_serial_waveform();
        payload_t b;
        payload_t got;
        logic     exp;
        logic     seen;
        int       fall_cycle;
        b    = 8'hA5;
        seen = 1'b0;
        got  = '0;
        send_frame(b);
        fall_cycle = cycle_count;
        for (int i = 0; i < FRAME_BITS; i++) begin
            repeat ((i == 0) ? HALF_BIT : CLKS_PER_BIT) @(negedge clk);
            if (i == 0) begin
                exp = 1'b0;
            end else if (i == FRAME_BITS - 1) begin
                exp = 1'b1;
            end else begin
                exp = b[i-1];
            end
            check_bit("o_tx", exp, tx_line);
        end
        while (!tx_done) begin
            @(negedge clk);
            if (rx_valid) begin
                seen = 1'b1; // the looped frame lands during the stop bit.
                got  = rx_data;
            end
        end
        check_cycles("o_tx_done low time", FRAME_BITS * CLKS_PER_BIT, cycle_count - fall_cycle);
        check_bit("o_rx_valid", 1'b1, seen);
        check_byte("o_rx_data", b, got);
    endtask

    task automatic loop_edge_bytes();
        payload_t edge_bytes [4] = '{8'h00, 8'hFF, 8'h55, 8'h80};
        payload_t got;
        logic     err;
        foreach (edge_bytes[i]) begin
            send_frame(edge_bytes[i]);
            wait_for_byte(got, err);
            check_byte("o_rx_data", edge_bytes[i], got);
            check_bit("o_rx_frame_err", 1'b0, err);
        end
    endtask

    task automatic loop_random_bytes();
        payload_t b;
        payload_t got;
        logic     err;
        for (int n = 0; n < RANDOM_FRAMES; n++) begin
            random_byte(b);
            send_frame(b);
            wait_for_byte(got, err);
            check_byte("o_rx_data", b, got);
            check_bit("o_rx_frame_err", 1'b0, err);
        end
    endtask

    task automatic send_back_to_back();
        payload_t first_byte;
        payload_t second_byte;
        payload_t got;
        logic     err;
        first_byte  = 8'hC3;
        second_byte = 8'h1E;
        @(negedge clk);
        while (!tx_done) @(negedge clk);
        tx_data  = first_byte;
        tx_start = 1'b1;
        while (tx_done) @(negedge clk);
        tx_data = second_byte; // request stays high into the next frame.
        wait_for_byte(got, err);
        check_byte("o_rx_data", first_byte, got);
        check_bit("o_rx_frame_err", 1'b0, err);
        while (!tx_done) @(negedge clk);
        while (tx_done) @(negedge clk);
        tx_start = 1'b0;
        wait_for_byte(got, err);
        check_byte("o_rx_data", second_byte, got);
        check_bit("o_rx_frame_err", 1'b0, err);
    endtask

    task automatic inject_framing_error();
        payload_t got;
        logic     err;
        @(negedge clk);
        while (!tx_done) @(negedge clk);
        tb_line      = 1'b1;
        line_from_tb = 1'b1;
        fork
            drive_line_frame(8'h3C, 1'b0);
            wait_for_byte(got, err);
        join
        check_byte("o_rx_data", 8'h3C, got);
        check_bit("o_rx_frame_err", 1'b1, err);
        fork
            drive_line_frame(8'hC5, 1'b1);
            wait_for_byte(got, err);
        join
        check_byte("o_rx_data", 8'hC5, got);
        check_bit("o_rx_frame_err", 1'b0, err);
    endtask

    initial begin
        tx_start     = 1'b0;
        tx_data      = '0;
        tb_line      = 1'b1;
        line_from_tb = 1'b0;
        lfsr_state   = LFSR_SEED;
        cycle_count  = 0;
        verify_reset_values();
        trace_serial_waveform();
        loop_edge_bytes();
        loop_random_bytes();
        send_back_to_back();
        inject_framing_error();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
